// ==== src/rob_macros.svh ====
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// entries per thread bank
`define ROB_DEPTH 16

// log2 of ROB_DEPTH
`define ROB_IDX_W 4

// instruction address width
`define PC_W 64

// architectural register number width
`define ARN_W 5

// physical register number width, 64-entry PRF
`define PRN_W 6

`endif

// ==== src/rob_pkg.sv ====
`include "rob_macros.svh"

package rob_pkg;

	typedef struct packed {
		logic                  thread; // 1 selects thread 2
		logic [`ROB_IDX_W-1:0] idx;
	} rob_tag_t;

	typedef struct packed {
		logic              valid;
		logic [`PC_W-1:0]  pc;
		logic              is_branch;
		logic [`ARN_W-1:0] arn_dest;
		logic [`PRN_W-1:0] prn_dest;
	} dispatch_slot_t;

	// both slots belong to the same thread
	typedef struct packed {
		logic           thread;
		dispatch_slot_t slot0;
		dispatch_slot_t slot1;
	} dispatch_req_t;

	typedef struct packed {
		logic             valid;
		rob_tag_t         tag;
		logic             mispredict;
		logic [`PC_W-1:0] target_pc;
	} complete_t;

	typedef enum logic [1:0] {
		ENTRY_FREE,
		ENTRY_ISSUED, // dispatched, waiting on execution
		ENTRY_DONE
	} entry_state_t;

	typedef struct packed {
		entry_state_t      state;
		logic [`PC_W-1:0]  pc;
		logic [`PC_W-1:0]  target_pc;
		logic              is_branch;
		logic              mispredict;
		logic [`ARN_W-1:0] arn_dest;
		logic [`PRN_W-1:0] prn_dest;
	} rob_entry_t;

	typedef struct packed {
		logic              valid;
		logic              thread;
		logic [`PC_W-1:0]  pc;
		logic [`PC_W-1:0]  target_pc;
		logic              is_branch;
		logic              mispredict;
		logic [`ARN_W-1:0] arn_dest;
		logic [`PRN_W-1:0] prn_dest;
	} commit_t;

endpackage

// ==== src/rob_bank.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_bank
	import rob_pkg::*;
#(
	parameter bit THREAD_ID = 1'b0
)
(
	input  logic                          clock,
	input  logic                          reset,
	input  dispatch_req_t                 load,
	input  logic                          load_en0,
	input  logic                          load_en1,
	input  logic [`ROB_IDX_W-1:0]         load_idx0,
	input  logic [`ROB_IDX_W-1:0]         load_idx1,
	input  complete_t                     complete0,
	input  complete_t                     complete1,
	input  logic [`ROB_DEPTH-1:0]         retire_mask,
	input  logic [`ROB_DEPTH-1:0]         flush_keep_mask,
	output rob_entry_t [`ROB_DEPTH-1:0]   entries
);

	logic [`ROB_DEPTH-1:0] hit0;
	logic [`ROB_DEPTH-1:0] hit1;

	function automatic logic tag_match(input complete_t c, input int unsigned i);
		return c.valid && (c.tag.thread == THREAD_ID) && (c.tag.idx == `ROB_IDX_W'(i));
	endfunction

	function automatic rob_entry_t new_entry(input dispatch_slot_t s);
		rob_entry_t e;
		e.state      = ENTRY_ISSUED;
		e.pc         = s.pc;
		e.target_pc  = '0; // filled in on completion
		e.is_branch  = s.is_branch;
		e.mispredict = 1'b0;
		e.arn_dest   = s.arn_dest;
		e.prn_dest   = s.prn_dest;
		return e;
	endfunction

	// completions aimed at a free slot are dropped
	always_comb
	begin
		for (int i = 0; i < `ROB_DEPTH; i++)
		begin
			hit0[i] = tag_match(complete0, i) && (entries[i].state != ENTRY_FREE);
			hit1[i] = tag_match(complete1, i) && (entries[i].state != ENTRY_FREE);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `ROB_DEPTH; i++)
				entries[i].state <= ENTRY_FREE;
		end
		else
		begin
			for (int i = 0; i < `ROB_DEPTH; i++)
			begin
				if (hit0[i])
				begin
					entries[i].state      <= ENTRY_DONE;
					entries[i].mispredict <= complete0.mispredict;
					entries[i].target_pc  <= complete0.target_pc;
				end
				if (hit1[i]) // port 1 wins a double hit
				begin
					entries[i].state      <= ENTRY_DONE;
					entries[i].mispredict <= complete1.mispredict;
					entries[i].target_pc  <= complete1.target_pc;
				end
				if (retire_mask[i] || !flush_keep_mask[i])
					entries[i].state <= ENTRY_FREE;
				if (load_en0 && load_idx0 == `ROB_IDX_W'(i))
					entries[i] <= new_entry(load.slot0);
				if (load_en1 && load_idx1 == `ROB_IDX_W'(i))
					entries[i] <= new_entry(load.slot1);
			end
		end
	end

endmodule

// ==== src/rob_control.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_control
	import rob_pkg::*;
(
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        dispatch_valid,
	input  dispatch_req_t               dispatch,
	input  rob_entry_t [`ROB_DEPTH-1:0] t1_entries,
	input  rob_entry_t [`ROB_DEPTH-1:0] t2_entries,
	input  logic                        commit_ready,
	output logic                        dispatch_ready,
	output rob_tag_t                    dispatch_tag0,
	output rob_tag_t                    dispatch_tag1,
	output logic                        t1_load_en0,
	output logic                        t1_load_en1,
	output logic [`ROB_IDX_W-1:0]       t1_load_idx0,
	output logic [`ROB_IDX_W-1:0]       t1_load_idx1,
	output logic                        t2_load_en0,
	output logic                        t2_load_en1,
	output logic [`ROB_IDX_W-1:0]       t2_load_idx0,
	output logic [`ROB_IDX_W-1:0]       t2_load_idx1,
	output rob_tag_t                    sel0,
	output rob_tag_t                    sel1,
	output logic                        sel0_valid,
	output logic                        sel1_valid,
	output logic [`ROB_DEPTH-1:0]       t1_retire_mask,
	output logic [`ROB_DEPTH-1:0]       t1_keep_mask,
	output logic [`ROB_DEPTH-1:0]       t2_retire_mask,
	output logic [`ROB_DEPTH-1:0]       t2_keep_mask
);

	typedef logic [`ROB_IDX_W:0] cnt_t;

	localparam cnt_t MAX_FILL = cnt_t'(`ROB_DEPTH - 2); // need two free slots to accept

	// index 0 is thread 1, index 1 is thread 2
	logic [1:0][`ROB_IDX_W-1:0] head;
	logic [1:0][`ROB_IDX_W-1:0] tail;
	logic [1:0][`ROB_IDX_W-1:0] head_next;
	logic [1:0][`ROB_IDX_W-1:0] tail_next;
	logic [1:0][`ROB_IDX_W-1:0] head_new;
	cnt_t [1:0]                 count;
	rob_entry_t [`ROB_DEPTH-1:0] bank [2];
	logic [1:0] head_done;
	logic [1:0] next_done;
	logic [1:0] head_mp;
	logic [1:0] next_mp;
	logic       s0t; // thread feeding slot 0
	logic       mp0;
	logic       mp1;
	logic [1:0][1:0] retire_n;
	logic [1:0][1:0] disp_n;
	logic [1:0] flush;
	logic [1:0] load_en0;
	logic [1:0] load_en1;
	logic [1:0][`ROB_DEPTH-1:0] retire_mask;
	logic       accept;

	always_comb
	begin
		bank[0] = t1_entries;
		bank[1] = t2_entries;
		for (int t = 0; t < 2; t++)
		begin
			head_next[t] = head[t] + `ROB_IDX_W'(1);
			tail_next[t] = tail[t] + `ROB_IDX_W'(1);
			head_done[t] = bank[t][head[t]].state == ENTRY_DONE;
			next_done[t] = bank[t][head_next[t]].state == ENTRY_DONE;
			head_mp[t]   = bank[t][head[t]].is_branch && bank[t][head[t]].mispredict;
			next_mp[t]   = bank[t][head_next[t]].is_branch && bank[t][head_next[t]].mispredict;
		end
	end

	// thread 1 first; slot 1 stays in-thread unless slot 0 redirects
	always_comb
	begin
		sel0       = '0;
		sel1       = '0;
		sel0_valid = head_done[0] || head_done[1];
		sel1_valid = 1'b0;
		s0t        = !head_done[0];
		mp0        = 1'b0;
		mp1        = 1'b0;
		if (sel0_valid)
		begin
			sel0.thread = s0t;
			sel0.idx    = head[s0t];
			mp0         = head_mp[s0t];
			if (next_done[s0t] && !mp0)
			begin
				sel1_valid  = 1'b1;
				sel1.thread = s0t;
				sel1.idx    = head_next[s0t];
				mp1         = next_mp[s0t];
			end
			else if (head_done[!s0t])
			begin
				sel1_valid  = 1'b1;
				sel1.thread = !s0t;
				sel1.idx    = head[!s0t];
				mp1         = head_mp[!s0t];
			end
		end
	end

	always_comb
	begin
		for (int t = 0; t < 2; t++)
		begin
			retire_n[t]    = 2'd0;
			retire_mask[t] = '0;
			flush[t]       = 1'b0;
			if (commit_ready && sel0_valid && sel0.thread == 1'(t))
			begin
				retire_n[t]              = retire_n[t] + 2'd1;
				retire_mask[t][sel0.idx] = 1'b1;
				flush[t]                 = flush[t] || mp0;
			end
			if (commit_ready && sel1_valid && sel1.thread == 1'(t))
			begin
				retire_n[t]              = retire_n[t] + 2'd1;
				retire_mask[t][sel1.idx] = 1'b1;
				flush[t]                 = flush[t] || mp1;
			end
			head_new[t] = head[t] + `ROB_IDX_W'(retire_n[t]);
		end
	end

	assign dispatch_ready = (count[dispatch.thread] <= MAX_FILL) && !flush[dispatch.thread];
	assign accept         = dispatch_valid && dispatch_ready;
	assign dispatch_tag0  = '{thread: dispatch.thread, idx: tail[dispatch.thread]};
	assign dispatch_tag1  = '{thread: dispatch.thread, idx: tail_next[dispatch.thread]};

	always_comb
	begin
		for (int t = 0; t < 2; t++)
		begin
			load_en0[t] = accept && dispatch.thread == 1'(t) && dispatch.slot0.valid;
			load_en1[t] = accept && dispatch.thread == 1'(t) && dispatch.slot1.valid;
			disp_n[t]   = {1'b0, load_en0[t]} + {1'b0, load_en1[t]};
		end
	end

	assign t1_load_en0    = load_en0[0];
	assign t1_load_en1    = load_en1[0];
	assign t1_load_idx0   = tail[0];
	assign t1_load_idx1   = tail_next[0];
	assign t2_load_en0    = load_en0[1];
	assign t2_load_en1    = load_en1[1];
	assign t2_load_idx0   = tail[1];
	assign t2_load_idx1   = tail_next[1];
	assign t1_retire_mask = retire_mask[0];
	assign t2_retire_mask = retire_mask[1];
	assign t1_keep_mask   = flush[0] ? '0 : '1; // flush empties everything past the branch
	assign t2_keep_mask   = flush[1] ? '0 : '1;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			for (int t = 0; t < 2; t++)
			begin
				head[t] <= head_new[t];
				if (flush[t])
				begin
					tail[t]  <= head_new[t]; // tail snaps back to the new head
					count[t] <= '0;
				end
				else
				begin
					tail[t]  <= tail[t] + `ROB_IDX_W'(disp_n[t]);
					count[t] <= count[t] - cnt_t'(retire_n[t]) + cnt_t'(disp_n[t]);
				end
			end
		end
	end

endmodule

// ==== src/rob_commit_mux.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_commit_mux
	import rob_pkg::*;
(
	input  rob_entry_t [`ROB_DEPTH-1:0] t1_entries,
	input  rob_entry_t [`ROB_DEPTH-1:0] t2_entries,
	input  rob_tag_t                    sel0,
	input  rob_tag_t                    sel1,
	input  logic                        sel0_valid,
	input  logic                        sel1_valid,
	output commit_t                     commit0,
	output commit_t                     commit1
);

	rob_entry_t entry0;
	rob_entry_t entry1;

	// turns a bank entry into a retirement record
	function automatic commit_t make_commit(input rob_entry_t e, input logic thread);
		commit_t c;
		c.valid      = 1'b1;
		c.thread     = thread;
		c.pc         = e.pc;
		c.target_pc  = e.target_pc;
		c.is_branch  = e.is_branch;
		c.mispredict = e.mispredict;
		c.arn_dest   = e.arn_dest;
		c.prn_dest   = e.prn_dest;
		return c;
	endfunction

	// thread bit picks the bank, index picks the entry
	always_comb
	begin
		if (sel0.thread)
			entry0 = t2_entries[sel0.idx];
		else
			entry0 = t1_entries[sel0.idx];
	end

	always_comb
	begin
		if (sel1.thread)
			entry1 = t2_entries[sel1.idx];
		else
			entry1 = t1_entries[sel1.idx];
	end

	always_comb
	begin
		commit0 = '0; // idle slots read as all zero
		commit1 = '0;
		if (sel0_valid)
			commit0 = make_commit(entry0, sel0.thread);
		if (sel1_valid)
			commit1 = make_commit(entry1, sel1.thread);
	end

endmodule

// ==== src/rob_top.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_top
	import rob_pkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  logic          dispatch_valid,
	input  dispatch_req_t dispatch,
	input  complete_t     complete0,
	input  complete_t     complete1,
	input  logic          commit_ready,
	output logic          dispatch_ready,
	output rob_tag_t      dispatch_tag0,
	output rob_tag_t      dispatch_tag1,
	output commit_t       commit0,
	output commit_t       commit1
);

	rob_entry_t [`ROB_DEPTH-1:0] t1_entries;
	rob_entry_t [`ROB_DEPTH-1:0] t2_entries;
	logic                  t1_load_en0;
	logic                  t1_load_en1;
	logic                  t2_load_en0;
	logic                  t2_load_en1;
	logic [`ROB_IDX_W-1:0] t1_load_idx0;
	logic [`ROB_IDX_W-1:0] t1_load_idx1;
	logic [`ROB_IDX_W-1:0] t2_load_idx0;
	logic [`ROB_IDX_W-1:0] t2_load_idx1;
	logic [`ROB_DEPTH-1:0] t1_retire_mask;
	logic [`ROB_DEPTH-1:0] t1_keep_mask;
	logic [`ROB_DEPTH-1:0] t2_retire_mask;
	logic [`ROB_DEPTH-1:0] t2_keep_mask;
	rob_tag_t              sel0;
	rob_tag_t              sel1;
	logic                  sel0_valid;
	logic                  sel1_valid;

	// thread 1 bank
	rob_bank #(.THREAD_ID(1'b0)) u_bank_t1 (
		.clock(clock), .reset(reset), .load(dispatch),
		.load_en0(t1_load_en0), .load_en1(t1_load_en1),
		.load_idx0(t1_load_idx0), .load_idx1(t1_load_idx1),
		.complete0(complete0), .complete1(complete1),
		.retire_mask(t1_retire_mask), .flush_keep_mask(t1_keep_mask),
		.entries(t1_entries)
	);

	rob_bank #(.THREAD_ID(1'b1)) u_bank_t2 (
		.clock(clock), .reset(reset), .load(dispatch),
		.load_en0(t2_load_en0), .load_en1(t2_load_en1),
		.load_idx0(t2_load_idx0), .load_idx1(t2_load_idx1),
		.complete0(complete0), .complete1(complete1),
		.retire_mask(t2_retire_mask), .flush_keep_mask(t2_keep_mask),
		.entries(t2_entries)
	);

	rob_control u_control (.*);

	rob_commit_mux u_commit_mux (.*); // combinational read of the selected heads

endmodule

// ==== test/tb_rob_tests.svh ====
`ifndef TB_ROB_TESTS_SVH
`define TB_ROB_TESTS_SVH

task automatic drive_idle();
	dispatch_valid = 1'b0;
	dispatch       = '0;
	complete0      = '0;
	complete1      = '0;
	commit_ready   = 1'b1;
endtask

// every test starts from a fresh reset
task automatic begin_test(input string name);
	test_name       = name;
	errors_at_start = errors;
	reset           = 1'b1;
	drive_idle();
	t1_q.delete();
	t2_q.delete();
	repeat (2)
		next_cycle();
	reset = 1'b0;
	check_value("ready after reset", 64'd1, 64'(dispatch_ready));
	check_value("commit after reset", 64'd0, 64'(commit0.valid));
endtask

task automatic end_test();
	tests_run++;
	if (errors == errors_at_start)
		$display("test %s ok", test_name);
	else
	begin
		tests_failed++;
		$display("test %s had %0d errors", test_name, errors - errors_at_start);
	end
endtask

function automatic dispatch_slot_t random_slot(input logic is_branch);
	dispatch_slot_t s;
	logic [31:0]    hi;
	logic [31:0]    lo;
	logic [31:0]    regs;
	hi          = lcg_next();
	lo          = lcg_next();
	regs        = lcg_next();
	s.valid     = 1'b1;
	s.pc        = {hi, lo[31:2], 2'b00}; // word aligned
	s.is_branch = is_branch;
	s.arn_dest  = regs[4:0];
	s.prn_dest  = regs[13:8];
	return s;
endfunction

task automatic push_expected(input logic thread, input dispatch_slot_t s);
	if (thread)
		t2_q.push_back(s);
	else
		t1_q.push_back(s);
endtask

task automatic dispatch_insts(input logic thread, input dispatch_slot_t s0,
	input dispatch_slot_t s1, output rob_tag_t tag0, output rob_tag_t tag1);
	int waited;
	waited          = 0;
	dispatch_valid  = 1'b1;
	dispatch.thread = thread;
	dispatch.slot0  = s0;
	dispatch.slot1  = s1;
	#1;
	while (!dispatch_ready && waited < TIMEOUT)
	begin
		next_cycle();
		#1;
		waited++;
	end
	tag0 = dispatch_tag0; // tags are valid in the same cycle
	tag1 = dispatch_tag1;
	if (!dispatch_ready)
		report_failure("dispatch_ready stayed low for 50 cycles");
	else
	begin
		push_expected(thread, s0);
		if (s1.valid)
			push_expected(thread, s1);
		next_cycle();
	end
	dispatch_valid = 1'b0;
endtask

task automatic complete_one(input rob_tag_t tag, input logic mispredict,
	input logic [63:0] target);
	complete0.valid      = 1'b1;
	complete0.tag        = tag;
	complete0.mispredict = mispredict;
	complete0.target_pc  = target;
	next_cycle();
	complete0 = '0;
endtask

task automatic complete_two(input rob_tag_t tag_a, input rob_tag_t tag_b);
	complete0.valid = 1'b1;
	complete0.tag   = tag_a;
	complete1.valid = 1'b1;
	complete1.tag   = tag_b;
	next_cycle();
	complete0 = '0;
	complete1 = '0;
endtask

task automatic wait_commit();
	int waited;
	waited = 0;
	while (!commit0.valid && waited < TIMEOUT)
	begin
		next_cycle();
		waited++;
	end
	if (!commit0.valid)
		report_failure("no commit appeared within 50 cycles");
endtask

task automatic check_commit(input commit_t c);
	dispatch_slot_t exp;
	bit             empty;
	empty = c.thread ? (t2_q.size() == 0) : (t1_q.size() == 0);
	if (empty)
		report_failure("commit seen with nothing pending for its thread");
	else
	begin
		if (c.thread)
			exp = t2_q.pop_front();
		else
			exp = t1_q.pop_front();
		check_value("commit pc", exp.pc, c.pc);
		check_value("commit is_branch", 64'(exp.is_branch), 64'(c.is_branch));
		check_value("commit arn", 64'(exp.arn_dest), 64'(c.arn_dest));
		check_value("commit prn", 64'(exp.prn_dest), 64'(c.prn_dest));
	end
endtask

// checks what is on the commit ports and lets it retire at the edge
task automatic retire_visible();
	if (commit0.valid)
		check_commit(commit0);
	if (commit1.valid)
		check_commit(commit1);
	next_cycle();
endtask

task automatic tags_in_order();
	rob_tag_t tags [4];
	begin_test("tags_in_order");
	dispatch_insts(1'b0, random_slot(1'b0), random_slot(1'b0), tags[0], tags[1]);
	dispatch_insts(1'b0, random_slot(1'b0), random_slot(1'b0), tags[2], tags[3]);
	for (int i = 0; i < 4; i++)
		check_value("dispatch tag", 64'(i), 64'(tags[i])); // thread bit is 0
	complete_one(tags[3], 1'b0, '0);
	check_value("commit before head done", 64'd0, 64'(commit0.valid));
	complete_one(tags[1], 1'b0, '0);
	check_value("commit before head done", 64'd0, 64'(commit0.valid));
	complete_one(tags[0], 1'b0, '0);
	wait_commit();
	check_value("second slot valid", 64'd1, 64'(commit1.valid));
	retire_visible();
	complete_one(tags[2], 1'b0, '0);
	wait_commit();
	retire_visible();
	check_value("pending after drain", 64'd0, 64'(t1_q.size()));
	end_test();
endtask

task automatic dual_commit_one_thread();
	rob_tag_t tag_a;
	rob_tag_t tag_b;
	begin_test("dual_commit_one_thread");
	dispatch_insts(1'b1, random_slot(1'b0), random_slot(1'b0), tag_a, tag_b);
	check_value("tag a", 64'h10, 64'(tag_a));
	check_value("tag b", 64'h11, 64'(tag_b));
	complete_two(tag_a, tag_b);
	wait_commit();
	check_value("commit0 thread", 64'd1, 64'(commit0.thread));
	check_value("commit1 valid", 64'd1, 64'(commit1.valid));
	check_value("commit1 thread", 64'd1, 64'(commit1.thread));
	retire_visible();
	check_value("pending after drain", 64'd0, 64'(t2_q.size()));
	end_test();
endtask

task automatic cross_thread_commit();
	rob_tag_t t1_tag;
	rob_tag_t t2_tag;
	rob_tag_t spare;
	begin_test("cross_thread_commit");
	dispatch_insts(1'b0, random_slot(1'b0), '0, t1_tag, spare);
	dispatch_insts(1'b1, random_slot(1'b0), '0, t2_tag, spare);
	complete_two(t1_tag, t2_tag);
	wait_commit();
	check_value("slot 0 thread", 64'd0, 64'(commit0.thread));
	check_value("slot 1 valid", 64'd1, 64'(commit1.valid));
	check_value("slot 1 thread", 64'd1, 64'(commit1.thread));
	retire_visible();
	check_value("pending after drain", 64'd0, 64'(t1_q.size() + t2_q.size()));
	end_test();
endtask

task automatic commit_back_pressure();
	rob_tag_t tag_a;
	rob_tag_t tag_b;
	begin_test("commit_back_pressure");
	commit_ready = 1'b0;
	dispatch_insts(1'b0, random_slot(1'b0), random_slot(1'b0), tag_a, tag_b);
	complete_two(tag_a, tag_b);
	wait_commit();
	repeat (4)
	begin
		next_cycle();
		check_value("held valid0", 64'd1, 64'(commit0.valid));
		check_value("held pc0", t1_q[0].pc, commit0.pc);
		check_value("held valid1", 64'd1, 64'(commit1.valid));
		check_value("held pc1", t1_q[1].pc, commit1.pc);
	end
	commit_ready = 1'b1;
	retire_visible();
	repeat (3)
	begin
		check_value("second retire", 64'd0, 64'(commit0.valid));
		next_cycle();
	end
	check_value("pending after drain", 64'd0, 64'(t1_q.size()));
	end_test();
endtask

task automatic mispredict_flush();
	rob_tag_t    tags [4];
	rob_tag_t    spare;
	logic [63:0] target;
	begin_test("mispredict_flush");
	target = {lcg_next(), lcg_next()};
	dispatch_insts(1'b0, random_slot(1'b1), random_slot(1'b0), tags[0], tags[1]);
	dispatch_insts(1'b0, random_slot(1'b0), random_slot(1'b0), tags[2], tags[3]);
	complete_two(tags[1], tags[2]); // younger entries finish first
	complete_one(tags[3], 1'b0, '0);
	check_value("commit before branch done", 64'd0, 64'(commit0.valid));
	complete_one(tags[0], 1'b1, target);
	wait_commit();
	check_value("branch is_branch", 64'd1, 64'(commit0.is_branch));
	check_value("branch mispredict", 64'd1, 64'(commit0.mispredict));
	check_value("branch target", target, commit0.target_pc);
	check_value("younger in slot 1", 64'd0, 64'(commit1.valid));
	retire_visible();
	t1_q.delete(); // the three younger entries are squashed
	repeat (3)
	begin
		check_value("younger commit", 64'd0, 64'(commit0.valid));
		next_cycle();
	end
	dispatch_insts(1'b0, random_slot(1'b0), '0, tags[0], spare);
	check_value("tag after flush", 64'd1, 64'(tags[0]));
	complete_one(tags[0], 1'b0, '0);
	wait_commit();
	retire_visible();
	check_value("pending after drain", 64'd0, 64'(t1_q.size()));
	end_test();
endtask

task automatic fill_to_full();
	rob_tag_t tag_a;
	rob_tag_t tag_b;
	begin_test("fill_to_full");
	for (int i = 0; i < 7; i++)
	begin
		dispatch_insts(1'b0, random_slot(1'b0), random_slot(1'b0), tag_a, tag_b);
		check_value("fill tag", 64'(2 * i), 64'(tag_a));
	end
	check_value("ready at 14 used", 64'd1, 64'(dispatch_ready));
	dispatch_insts(1'b0, random_slot(1'b0), '0, tag_a, tag_b);
	check_value("ready at 15 used", 64'd0, 64'(dispatch_ready));
	dispatch.thread = 1'b1; // other thread still has room
	#1;
	check_value("thread 2 ready", 64'd1, 64'(dispatch_ready));
	end_test();
endtask

`endif

// ==== test/tb_rob_top.sv ====
`timescale 1ns/1ps
`include "rob_macros.svh"

module tb_rob_top
	import rob_pkg::*;
();

	localparam int TIMEOUT = 50; // cycles allowed per wait

	logic          clock;
	logic          reset;
	logic          dispatch_valid;
	dispatch_req_t dispatch;
	complete_t     complete0;
	complete_t     complete1;
	logic          commit_ready;
	logic          dispatch_ready;
	rob_tag_t      dispatch_tag0;
	rob_tag_t      dispatch_tag1;
	commit_t       commit0;
	commit_t       commit1;

	logic [31:0]    lcg_state;
	string          test_name;
	int             errors;
	int             checks;
	int             tests_run;
	int             tests_failed;
	int             errors_at_start;
	dispatch_slot_t t1_q [$]; // dispatched records in program order
	dispatch_slot_t t2_q [$];

	rob_top u_rob_top (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual)
		begin
			$display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("test %s: %s", test_name, what);
		errors++;
	endtask

	// inputs change a little after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	`include "tb_rob_tests.svh"

	initial
	begin
		lcg_state    = 32'd28833;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset        = 1'b1;
		drive_idle();
		tags_in_order();
		dual_commit_one_thread();
		cross_thread_commit();
		commit_back_pressure();
		mispredict_flush();
		fill_to_full();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== rob_top.f ====
+incdir+src
+incdir+test
src/rob_pkg.sv
src/rob_bank.sv
src/rob_control.sv
src/rob_commit_mux.sv
src/rob_top.sv
test/tb_rob_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the reorder buffer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_rob_top \
	-f rob_top.f \
	-o sim_rob_top

output="$(./obj_dir/sim_rob_top)"
echo "$output"

# exit status of the search is the result of the run
echo "$output" | grep -qx "sim passed"
